//--- list.f
+incdir+include
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_memory.sv
verilog/rv_hazard.sv
verilog/rv_core.sv
bench/rv_core_tb.sv

//--- bench/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core_tb
    import rv_pkg::*;
();

    localparam int    N_RANDOM   = 200;
    localparam int    PROG_LEN   = 16 + N_RANDOM + 1;
    localparam int    LAST       = PROG_LEN - 1;   // Self-loop slot.
    localparam word_t END_ADDR   = `RV_RESET_PC + 4 * LAST;
    localparam int    MAX_CYCLES = 4 * (PROG_LEN + 16) + 50;
    localparam word_t NOP        = 32'h0000_0013;

    logic      clk, rst;
    word_t     imem_data, imem_addr;
    logic      retire_valid;
    reg_addr_t retire_rd;
    word_t     retire_data, a0, a1;

    word_t     prog [PROG_LEN];
    word_t     ref_regs [`RV_REGS];
    word_t     ref_mem [`RV_DMEM_WORDS];
    reg_addr_t exp_rd_q [$];
    word_t     exp_data_q [$];
    integer    seed;
    int        cycles;
    logic      running;

    rv_core dut0 (
        .clk(clk), .rst(rst),
        .imem_data_i(imem_data), .imem_addr_o(imem_addr),
        .retire_valid_o(retire_valid), .retire_rd_o(retire_rd),
        .retire_data_o(retire_data), .a0_o(a0), .a1_o(a1)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t expected,
                             input reg_addr_t actual);
        if (actual !== expected) begin
            $display("Fail time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Fail time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic word_t b_type(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic word_t u_type(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, LUI};
    endfunction

    function automatic word_t j_type(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    task automatic build_program();
        int unsigned kind, k;
        reg_addr_t   rd, rs1, rs2;
        logic [11:0] imm12, offs;
        for (int i = 0; i < 16; i++) begin
            prog[i] = s_type(12'(4 * i), 5'd0, 5'd0);   // Clear data words 0 to 15.
        end
        for (int i = 16; i < LAST; i++) begin
            kind  = $unsigned($random(seed)) % 16;
            rd    = reg_addr_t'(1 + $unsigned($random(seed)) % 15);
            rs1   = reg_addr_t'(1 + $unsigned($random(seed)) % 15);
            rs2   = reg_addr_t'(1 + $unsigned($random(seed)) % 15);
            imm12 = 12'($random(seed));
            offs  = 12'(4 * ($unsigned($random(seed)) % 16));
            k     = 1 + $unsigned($random(seed)) % 4;
            if (i + k > LAST) k = LAST - i;   // Never past the self-loop.
            case (kind)
                0:  prog[i] = r_type(7'h00, rs2, rs1, 3'b000, rd);
                1:  prog[i] = r_type(7'h20, rs2, rs1, 3'b000, rd);
                2:  prog[i] = r_type(7'h00, rs2, rs1, 3'b111, rd);
                3:  prog[i] = r_type(7'h00, rs2, rs1, 3'b110, rd);
                4:  prog[i] = r_type(7'h00, rs2, rs1, 3'b100, rd);
                5:  prog[i] = r_type(7'h00, rs2, rs1, 3'b010, rd);
                6:  prog[i] = i_type(imm12, rs1, 3'b000, rd, OP_IMM);
                7:  prog[i] = i_type(imm12, rs1, 3'b111, rd, OP_IMM);
                8:  prog[i] = i_type(imm12, rs1, 3'b110, rd, OP_IMM);
                9:  prog[i] = i_type(imm12, rs1, 3'b100, rd, OP_IMM);
                10: prog[i] = i_type(imm12, rs1, 3'b010, rd, OP_IMM);
                11: prog[i] = u_type(20'($random(seed)), rd);
                12: prog[i] = i_type(offs, 5'd0, 3'b010, rd, LOAD);
                13: prog[i] = s_type(offs, rs2, 5'd0);
                14: begin
                    if ($random(seed) % 4 == 0) rs2 = rs1;   // Some beq taken.
                    prog[i] = b_type(13'(4 * k), rs2, rs1, 3'($unsigned($random(seed)) % 2));
                end
                default: prog[i] = j_type(21'(4 * k), rd);
            endcase
        end
        prog[LAST] = j_type(21'd0, 5'd0);
    endtask

    function automatic word_t alu_ref(logic [2:0] f3, logic sub, word_t a, word_t b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 'x;
        endcase
    endfunction

    task automatic model_write(input reg_addr_t rd, input word_t data);
        if (rd != '0) begin
            ref_regs[rd] = data;
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(data);
        end
    endtask

    // Sequential ISA model over the whole program.
    task automatic run_model();
        word_t pc, pc_next, instr, a, b, imm, addr;
        int    steps;
        pc    = `RV_RESET_PC;
        steps = 0;
        for (int i = 0; i < `RV_REGS; i++) begin
            ref_regs[i] = '0;
        end
        while (pc != END_ADDR) begin
            instr   = prog[(pc - `RV_RESET_PC) >> 2];
            a       = ref_regs[instr[19:15]];
            b       = ref_regs[instr[24:20]];
            imm     = {{20{instr[31]}}, instr[31:20]};
            pc_next = pc + 32'd4;
            case (instr[6:0])
                OP:     model_write(instr[11:7], alu_ref(instr[14:12], instr[30], a, b));
                OP_IMM: model_write(instr[11:7], alu_ref(instr[14:12], 1'b0, a, imm));
                LUI:    model_write(instr[11:7], {instr[31:12], 12'b0});
                LOAD: begin
                    addr = a + imm;
                    model_write(instr[11:7], ref_mem[(addr >> 2) % `RV_DMEM_WORDS]);
                end
                STORE: begin
                    addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    ref_mem[(addr >> 2) % `RV_DMEM_WORDS] = b;
                end
                BRANCH: begin
                    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
                    if ((a == b) != instr[12]) pc_next = pc + imm;
                end
                JAL: begin
                    model_write(instr[11:7], pc + 32'd4);
                    pc_next = pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                    instr[30:21], 1'b0};
                end
                default: ;
            endcase
            pc = pc_next;
            steps++;
            if (steps > PROG_LEN) begin
                $display("Reference model ran past the end of the program");
                abort_run();
            end
        end
    endtask

    function automatic word_t fetch_word(word_t addr);
        word_t idx;
        idx = (addr - `RV_RESET_PC) >> 2;
        if (addr[1:0] == 2'b00 && idx < PROG_LEN) return prog[idx];
        else return NOP;   // Wrong-path fetch past the end.
    endfunction

    always @(posedge clk) begin
        #2;
        imem_data = fetch_word(imem_addr);
    end

    // Retirement and timeout monitor.
    always @(negedge clk) begin
        reg_addr_t exp_rd;
        word_t     exp_data;
        if (running) begin
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("Timeout after %0d cycles, core did not reach the end of the program",
                         cycles);
                abort_run();
            end
            if (retire_valid !== 1'b0 && retire_valid !== 1'b1) begin
                $display("retire_valid_o is unknown at time %0t", $time);
                abort_run();
            end
            if (retire_valid) begin
                if (exp_rd_q.size() == 0) begin
                    $display("Retirement at time %0t with no result left in the model", $time);
                    abort_run();
                end
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                check_reg("retire_rd_o", exp_rd, retire_rd);
                check_word("retire_data_o", exp_data, retire_data);
            end
        end
    end

    initial begin
        seed      = 42;
        rst       = 1'b0;
        imem_data = NOP;
        running   = 1'b0;
        cycles    = 0;
        build_program();
        run_model();
        repeat (4) @(posedge clk);
        #2;
        check_bit("retire_valid_o", 1'b0, retire_valid);
        check_word("imem_addr_o", `RV_RESET_PC, imem_addr);
        rst     = 1'b1;
        running = 1'b1;
        while (!(imem_addr == END_ADDR && exp_rd_q.size() == 0)) begin
            @(posedge clk);
            #5;
        end
        repeat (5) @(posedge clk);
        #5;
        check_word("a0_o", ref_regs[10], a0);
        check_word("a1_o", ref_regs[11], a1);
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_t     imem_data_i,
    output word_t     imem_addr_o,
    output logic      retire_valid_o,
    output reg_addr_t retire_rd_o,
    output word_t     retire_data_o,
    output word_t     a0_o,
    output word_t     a1_o
);

    // Fetch and decode.
    word_t       instr_d, pc_d, pc_plus4_d;
    reg_addr_t   rs1_d, rs2_d;

    // Execute.
    logic        reg_write_e, mem_write_e, branch_e, branch_ne_e, jump_e, alu_src_imm_e;
    result_src_t result_src_e;
    alu_op_t     alu_op_e;
    word_t       rd1_e, rd2_e, imm_e, pc_e, pc_plus4_e, pc_target_e;
    reg_addr_t   rs1_e, rs2_e, rd_e;
    logic        pc_src_e, load_e;

    // Memory and writeback.
    logic        reg_write_m, mem_write_m, wb_we;
    result_src_t result_src_m;
    reg_addr_t   rd_m, wb_rd;
    word_t       alu_result_m, write_data_m, pc_plus4_m, wb_data;

    // Hazard control.
    logic        stall_f, stall_d, flush_d, flush_e;
    fwd_sel_t    fwd_a_e, fwd_b_e;

    assign load_e = (result_src_e == RES_MEM);

    rv_fetch u_fetch (
        .clk(clk), .rst(rst),
        .stall_f_i(stall_f), .stall_d_i(stall_d), .flush_d_i(flush_d),
        .pc_src_i(pc_src_e), .pc_target_i(pc_target_e),
        .imem_data_i(imem_data_i), .imem_addr_o(imem_addr_o),
        .instr_d_o(instr_d), .pc_d_o(pc_d), .pc_plus4_d_o(pc_plus4_d)
    );

    rv_decode u_decode (
        .clk(clk), .rst(rst),
        .instr_d_i(instr_d), .pc_d_i(pc_d), .pc_plus4_d_i(pc_plus4_d),
        .flush_e_i(flush_e),
        .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .rs1_d_o(rs1_d), .rs2_d_o(rs2_d),
        .reg_write_e_o(reg_write_e), .mem_write_e_o(mem_write_e),
        .branch_e_o(branch_e), .branch_ne_e_o(branch_ne_e), .jump_e_o(jump_e),
        .alu_src_imm_e_o(alu_src_imm_e), .result_src_e_o(result_src_e),
        .alu_op_e_o(alu_op_e), .rd1_e_o(rd1_e), .rd2_e_o(rd2_e), .imm_e_o(imm_e),
        .pc_e_o(pc_e), .pc_plus4_e_o(pc_plus4_e),
        .rs1_e_o(rs1_e), .rs2_e_o(rs2_e), .rd_e_o(rd_e),
        .a0_o(a0_o), .a1_o(a1_o)
    );

    rv_execute u_execute (
        .clk(clk), .rst(rst),
        .reg_write_e_i(reg_write_e), .mem_write_e_i(mem_write_e),
        .branch_e_i(branch_e), .branch_ne_e_i(branch_ne_e), .jump_e_i(jump_e),
        .alu_src_imm_e_i(alu_src_imm_e), .result_src_e_i(result_src_e),
        .alu_op_e_i(alu_op_e), .rd1_e_i(rd1_e), .rd2_e_i(rd2_e), .imm_e_i(imm_e),
        .pc_e_i(pc_e), .pc_plus4_e_i(pc_plus4_e), .rd_e_i(rd_e),
        .fwd_a_i(fwd_a_e), .fwd_b_i(fwd_b_e),
        .mem_fwd_i(alu_result_m), .wb_fwd_i(wb_data),
        .pc_src_o(pc_src_e), .pc_target_o(pc_target_e),
        .reg_write_m_o(reg_write_m), .mem_write_m_o(mem_write_m),
        .result_src_m_o(result_src_m), .rd_m_o(rd_m),
        .alu_result_m_o(alu_result_m), .write_data_m_o(write_data_m),
        .pc_plus4_m_o(pc_plus4_m)
    );

    rv_memory u_memory (
        .clk(clk), .rst(rst),
        .reg_write_m_i(reg_write_m), .mem_write_m_i(mem_write_m),
        .result_src_m_i(result_src_m), .rd_m_i(rd_m),
        .alu_result_m_i(alu_result_m), .write_data_m_i(write_data_m),
        .pc_plus4_m_i(pc_plus4_m),
        .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
    );

    rv_hazard u_hazard (
        .rs1_d_i(rs1_d), .rs2_d_i(rs2_d), .rs1_e_i(rs1_e), .rs2_e_i(rs2_e),
        .rd_e_i(rd_e), .rd_m_i(rd_m), .rd_w_i(wb_rd),
        .load_e_i(load_e), .reg_write_m_i(reg_write_m), .reg_write_w_i(wb_we),
        .pc_src_i(pc_src_e),
        .fwd_a_o(fwd_a_e), .fwd_b_o(fwd_b_e),
        .stall_f_o(stall_f), .stall_d_o(stall_d),
        .flush_d_o(flush_d), .flush_e_o(flush_e)
    );

    // Writes to x0 are not retirements.
    assign retire_valid_o = wb_we && wb_rd != '0;
    assign retire_rd_o    = wb_rd;
    assign retire_data_o  = wb_data;

endmodule

//--- verilog/rv_hazard.sv
`timescale 1ns/1ps

module rv_hazard
    import rv_pkg::*;
(
    input  reg_addr_t rs1_d_i,
    input  reg_addr_t rs2_d_i,
    input  reg_addr_t rs1_e_i,
    input  reg_addr_t rs2_e_i,
    input  reg_addr_t rd_e_i,
    input  reg_addr_t rd_m_i,
    input  reg_addr_t rd_w_i,
    input  logic      load_e_i,
    input  logic      reg_write_m_i,
    input  logic      reg_write_w_i,
    input  logic      pc_src_i,
    output fwd_sel_t  fwd_a_o,
    output fwd_sel_t  fwd_b_o,
    output logic      stall_f_o,
    output logic      stall_d_o,
    output logic      flush_d_o,
    output logic      flush_e_o
);

    logic load_use;

    // Youngest producer first.
    function automatic fwd_sel_t fwd_pick(reg_addr_t rs, reg_addr_t rd_m, logic we_m,
                                          reg_addr_t rd_w, logic we_w);
        if (rs == '0)                return FWD_REG;
        else if (we_m && rd_m == rs) return FWD_MEM;
        else if (we_w && rd_w == rs) return FWD_WB;
        else                         return FWD_REG;
    endfunction

    assign fwd_a_o = fwd_pick(rs1_e_i, rd_m_i, reg_write_m_i, rd_w_i, reg_write_w_i);
    assign fwd_b_o = fwd_pick(rs2_e_i, rd_m_i, reg_write_m_i, rd_w_i, reg_write_w_i);

    assign load_use  = load_e_i && rd_e_i != '0 && (rd_e_i == rs1_d_i || rd_e_i == rs2_d_i);
    assign stall_f_o = load_use;
    assign stall_d_o = load_use;
    assign flush_d_o = pc_src_i;
    assign flush_e_o = pc_src_i || load_use;   // Bubble behind the load.

endmodule

//--- verilog/rv_memory.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_memory
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        reg_write_m_i,
    input  logic        mem_write_m_i,
    input  result_src_t result_src_m_i,
    input  reg_addr_t   rd_m_i,
    input  word_t       alu_result_m_i,
    input  word_t       write_data_m_i,
    input  word_t       pc_plus4_m_i,
    output logic        wb_we_o,
    output reg_addr_t   wb_rd_o,
    output word_t       wb_data_o
);

    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

    word_t               dmem [`RV_DMEM_WORDS];
    logic [DMEM_AW-1:0]  word_idx;
    word_t               read_data, result;

    // Word index, wraps at the memory depth.
    assign word_idx = alu_result_m_i[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (mem_write_m_i) begin
            dmem[word_idx] <= write_data_m_i;
        end
    end

    assign read_data = dmem[word_idx];

    always_comb begin
        case (result_src_m_i)
            RES_MEM: result = read_data;
            RES_PC4: result = pc_plus4_m_i;
            default: result = alu_result_m_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= reg_write_m_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= rd_m_i;
        wb_data_o <= result;
    end

endmodule

//--- verilog/rv_execute.sv
`timescale 1ns/1ps

module rv_execute
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        reg_write_e_i,
    input  logic        mem_write_e_i,
    input  logic        branch_e_i,
    input  logic        branch_ne_e_i,
    input  logic        jump_e_i,
    input  logic        alu_src_imm_e_i,
    input  result_src_t result_src_e_i,
    input  alu_op_t     alu_op_e_i,
    input  word_t       rd1_e_i,
    input  word_t       rd2_e_i,
    input  word_t       imm_e_i,
    input  word_t       pc_e_i,
    input  word_t       pc_plus4_e_i,
    input  reg_addr_t   rd_e_i,
    input  fwd_sel_t    fwd_a_i,
    input  fwd_sel_t    fwd_b_i,
    input  word_t       mem_fwd_i,
    input  word_t       wb_fwd_i,
    output logic        pc_src_o,
    output word_t       pc_target_o,
    output logic        reg_write_m_o,
    output logic        mem_write_m_o,
    output result_src_t result_src_m_o,
    output reg_addr_t   rd_m_o,
    output word_t       alu_result_m_o,
    output word_t       write_data_m_o,
    output word_t       pc_plus4_m_o
);

    word_t src_a, src_b_reg, src_b, alu_result;
    logic  equal;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a     = fwd_mux(fwd_a_i, rd1_e_i, mem_fwd_i, wb_fwd_i);
    assign src_b_reg = fwd_mux(fwd_b_i, rd2_e_i, mem_fwd_i, wb_fwd_i);
    assign src_b     = alu_src_imm_e_i ? imm_e_i : src_b_reg;

    always_comb begin
        case (alu_op_e_i)
            ALU_SUB:    alu_result = src_a - src_b;
            ALU_AND:    alu_result = src_a & src_b;
            ALU_OR:     alu_result = src_a | src_b;
            ALU_XOR:    alu_result = src_a ^ src_b;
            ALU_SLT:    alu_result = word_t'($signed(src_a) < $signed(src_b));
            ALU_PASS_B: alu_result = src_b;
            default:    alu_result = src_a + src_b;
        endcase
    end

    assign equal       = (src_a == src_b_reg);
    assign pc_src_o    = jump_e_i || (branch_e_i && (equal != branch_ne_e_i));
    assign pc_target_o = pc_e_i + imm_e_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            reg_write_m_o <= 1'b0;
            mem_write_m_o <= 1'b0;
        end else begin
            reg_write_m_o <= reg_write_e_i;
            mem_write_m_o <= mem_write_e_i;
        end
    end

    always_ff @(posedge clk) begin
        result_src_m_o <= result_src_e_i;
        rd_m_o         <= rd_e_i;
        alu_result_m_o <= alu_result;
        write_data_m_o <= src_b_reg;   // Store data after forwarding.
        pc_plus4_m_o   <= pc_plus4_e_i;
    end

endmodule

//--- verilog/rv_decode.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  word_t       instr_d_i,
    input  word_t       pc_d_i,
    input  word_t       pc_plus4_d_i,
    input  logic        flush_e_i,
    input  logic        wb_we_i,
    input  reg_addr_t   wb_rd_i,
    input  word_t       wb_data_i,
    output reg_addr_t   rs1_d_o,
    output reg_addr_t   rs2_d_o,
    output logic        reg_write_e_o,
    output logic        mem_write_e_o,
    output logic        branch_e_o,
    output logic        branch_ne_e_o,
    output logic        jump_e_o,
    output logic        alu_src_imm_e_o,
    output result_src_t result_src_e_o,
    output alu_op_t     alu_op_e_o,
    output word_t       rd1_e_o,
    output word_t       rd2_e_o,
    output word_t       imm_e_o,
    output word_t       pc_e_o,
    output word_t       pc_plus4_e_o,
    output reg_addr_t   rs1_e_o,
    output reg_addr_t   rs2_e_o,
    output reg_addr_t   rd_e_o,
    output word_t       a0_o,
    output word_t       a1_o
);

    word_t       regs [`RV_REGS];
    reg_addr_t   rs1, rs2, rd;
    logic [2:0]  funct3;
    logic        reg_write, mem_write, branch, jump, alu_src_imm;
    result_src_t result_src;
    alu_op_t     alu_op, alu_op_f3;
    word_t       imm, rd1, rd2;

    assign rs1     = instr_d_i[19:15];
    assign rs2     = instr_d_i[24:20];
    assign rd      = instr_d_i[11:7];
    assign funct3  = instr_d_i[14:12];
    assign rs1_d_o = rs1;
    assign rs2_d_o = rs2;

    // Shared by register and immediate ALU forms.
    always_comb begin
        case (funct3)
            3'b010:  alu_op_f3 = ALU_SLT;
            3'b100:  alu_op_f3 = ALU_XOR;
            3'b110:  alu_op_f3 = ALU_OR;
            3'b111:  alu_op_f3 = ALU_AND;
            default: alu_op_f3 = ALU_ADD;
        endcase
    end

    always_comb begin
        reg_write   = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        alu_src_imm = 1'b0;
        result_src  = RES_ALU;
        alu_op      = ALU_ADD;
        imm         = {{20{instr_d_i[31]}}, instr_d_i[31:20]};
        case (opcode_t'(instr_d_i[6:0]))
            OP: begin
                reg_write = 1'b1;
                alu_op    = (funct3 == 3'b000 && instr_d_i[30]) ? ALU_SUB : alu_op_f3;
            end
            OP_IMM: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = alu_op_f3;
            end
            LUI: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = ALU_PASS_B;
                imm         = {instr_d_i[31:12], 12'b0};
            end
            LOAD: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                result_src  = RES_MEM;
            end
            STORE: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                imm = {{20{instr_d_i[31]}}, instr_d_i[31:25], instr_d_i[11:7]};
            end
            BRANCH: begin
                branch = 1'b1;
                imm = {{19{instr_d_i[31]}}, instr_d_i[31], instr_d_i[7],
                       instr_d_i[30:25], instr_d_i[11:8], 1'b0};
            end
            JAL: begin
                reg_write  = 1'b1;
                jump       = 1'b1;
                result_src = RES_PC4;
                imm = {{11{instr_d_i[31]}}, instr_d_i[31], instr_d_i[19:12],
                       instr_d_i[20], instr_d_i[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `RV_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // Same-cycle writeback is visible to the read.
    assign rd1 = (rs1 == '0) ? '0 : (wb_we_i && wb_rd_i == rs1) ? wb_data_i : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : (wb_we_i && wb_rd_i == rs2) ? wb_data_i : regs[rs2];

    assign a0_o = regs[10];
    assign a1_o = regs[11];

    always_ff @(posedge clk) begin
        if (!rst || flush_e_i) begin
            reg_write_e_o  <= 1'b0;
            mem_write_e_o  <= 1'b0;
            branch_e_o     <= 1'b0;
            jump_e_o       <= 1'b0;
            result_src_e_o <= RES_ALU;   // A bubble is never a load.
        end else begin
            reg_write_e_o  <= reg_write;
            mem_write_e_o  <= mem_write;
            branch_e_o     <= branch;
            jump_e_o       <= jump;
            result_src_e_o <= result_src;
        end
    end

    always_ff @(posedge clk) begin
        branch_ne_e_o   <= funct3[0];
        alu_src_imm_e_o <= alu_src_imm;
        alu_op_e_o      <= alu_op;
        rd1_e_o         <= rd1;
        rd2_e_o         <= rd2;
        imm_e_o         <= imm;
        pc_e_o          <= pc_d_i;
        pc_plus4_e_o    <= pc_plus4_d_i;
        rs1_e_o         <= rs1;
        rs2_e_o         <= rs2;
        rd_e_o          <= rd;
    end

endmodule

//--- verilog/rv_fetch.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_fetch
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  stall_f_i,
    input  logic  stall_d_i,
    input  logic  flush_d_i,
    input  logic  pc_src_i,
    input  word_t pc_target_i,
    input  word_t imem_data_i,
    output word_t imem_addr_o,
    output word_t instr_d_o,
    output word_t pc_d_o,
    output word_t pc_plus4_d_o
);

    localparam word_t NOP = 32'h0000_0013;   // addi x0,x0,0

    word_t pc, pc_plus4;

    assign pc_plus4    = pc + 32'd4;
    assign imem_addr_o = pc;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= `RV_RESET_PC;
        end else if (pc_src_i) begin
            pc <= pc_target_i;   // Redirect wins over a stall.
        end else if (!stall_f_i) begin
            pc <= pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst || flush_d_i) begin
            instr_d_o <= NOP;
        end else if (!stall_d_i) begin
            instr_d_o    <= imem_data_i;
            pc_d_o       <= pc;
            pc_plus4_d_o <= pc_plus4;
        end
    end

endmodule

//--- verilog/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]          word_t;
    typedef logic [$clog2(`RV_REGS)-1:0]  reg_addr_t;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B   // Lui.
    } alu_op_t;

    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} result_src_t;

    // Operand source in execute.
    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_t;

endpackage

//--- include/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data and address width.
`define RV_XLEN 32

// Architectural registers.
`define RV_REGS 32

// Data memory depth in words.
`define RV_DMEM_WORDS 64

// First fetch address.
`define RV_RESET_PC 32'h0000_0000

`endif
